// File: common/ctrl_pkg.sv
package ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // instruction format
    ////////////////////////////////////////////////////////////

    // 6-bit opcode, octal map below
    typedef logic [5:0] opcode_t;

    // ALU operation, bits 4..1 of an ALU opcode
    typedef logic [3:0] alu_op_t;

    localparam int ALU_OP_MSB = 4;
    localparam int ALU_OP_LSB = 1;

    // bit 0 of an ALU opcode selects the immediate operand
    localparam int IMM_BIT = 0;

    ////////////////////////////////////////////////////////////
    // opcode map
    ////////////////////////////////////////////////////////////

    // 00 through 37 are all ALU operations
    localparam opcode_t OPC_ALU_LAST  = 6'o37;

    localparam opcode_t OPC_LOAD      = 6'o40;
    localparam opcode_t OPC_LOAD_IMM  = 6'o41;
    localparam opcode_t OPC_STORE     = 6'o42;
    localparam opcode_t OPC_STORE_IMM = 6'o43;
    localparam opcode_t OPC_IO_IN     = 6'o44;
    localparam opcode_t OPC_IO_OUT    = 6'o45;

    ////////////////////////////////////////////////////////////
    // decoded classes and writeback sources
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        CLASS_ALU,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_IO_IN,
        CLASS_IO_OUT,
        CLASS_ILLEGAL
    } op_class_t;

    // SRC_ALU doubles as the idle value on the wb_src outputs
    typedef enum logic [1:0]
    {
        SRC_ALU,
        SRC_MEM,
        SRC_IO
    } wb_src_t;

endpackage

// File: filelist.f
common/ctrl_pkg.sv
rtl/opcode_decoder.sv
rtl/fetch_sequencer.sv
rtl/execute_sequencer.sv
rtl/writeback_sequencer.sv
rtl/pipeline_controller.sv
test/tb_pipeline_controller.sv

// File: rtl/execute_sequencer.sv
module execute_sequencer
(
    input  logic                clk,
    input  logic                reset,
    input  logic                issue,
    input  ctrl_pkg::op_class_t issue_class,
    input  ctrl_pkg::alu_op_t   issue_alu_op,
    input  logic                issue_imm,
    input  logic                wb_idle,
    input  logic                data_valid,
    input  logic                io_ack,
    output logic                exec_idle,
    output logic                alu_en,
    output ctrl_pkg::alu_op_t   alu_op,
    output logic                alu_use_imm,
    output logic                mem_read,
    output logic                mem_write,
    output logic                io_req,
    output logic                io_dir,
    output logic                illegal_op,
    output logic                wb_start,
    output ctrl_pkg::wb_src_t   wb_start_src
);
    import ctrl_pkg::*;

    typedef enum logic [2:0]
    {
        E_IDLE,
        E_ALU,
        E_LOAD,
        E_STORE_WAIT,
        E_IO_REQ,
        E_IO_REL,
        E_ILLEGAL
    } exec_state_t;

    exec_state_t state;
    exec_state_t state_next;

    alu_op_t op_q;
    logic    imm_q;
    logic    dir_out_q;
    logic    io_in_done;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= E_IDLE;
        else
            state <= state_next;
    end

    // payload of the issued instruction
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            op_q      <= issue_alu_op;
            imm_q     <= issue_imm;
            dir_out_q <= (issue_class == CLASS_IO_OUT);
        end
    end

    ////////////////////////////////////////////////////////////
    // class sequencing
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            E_IDLE:
            begin
                if (issue)
                begin
                    case (issue_class)
                        CLASS_ALU:    state_next = E_ALU;
                        CLASS_LOAD:   state_next = E_LOAD;
                        CLASS_STORE:  state_next = E_STORE_WAIT;
                        CLASS_IO_IN,
                        CLASS_IO_OUT: state_next = E_IO_REQ;
                        default:      state_next = E_ILLEGAL;
                    endcase
                end
            end
            E_ALU,
            E_LOAD:
            begin
                if (wb_idle)
                    state_next = E_IDLE;
            end
            E_STORE_WAIT:
            begin
                if (wb_idle && data_valid)
                    state_next = E_IDLE;
            end
            E_IO_REQ:
            begin
                if (io_ack)
                    state_next = E_IO_REL;
            end
            E_IO_REL:
            begin
                // input still needs a free writeback stage
                if (!io_ack && (dir_out_q || wb_idle))
                    state_next = E_IDLE;
            end
            default:
                state_next = E_IDLE;
        endcase
    end

    // memory use only while writeback is idle, so data_valid is unambiguous
    assign exec_idle   = (state == E_IDLE);
    assign alu_en      = (state == E_ALU) && wb_idle;
    assign alu_op      = alu_en ? op_q : '0;
    assign alu_use_imm = alu_en && imm_q;
    assign mem_read    = (state == E_LOAD) && wb_idle;
    assign mem_write   = (state == E_STORE_WAIT) && wb_idle;
    assign io_req      = (state == E_IO_REQ);
    assign io_dir      = io_req && dir_out_q;
    assign illegal_op  = (state == E_ILLEGAL);
    assign io_in_done  = (state == E_IO_REL) && !io_ack && !dir_out_q && wb_idle;
    assign wb_start    = alu_en || mem_read || io_in_done;

    always_comb
    begin
        case (state)
            E_LOAD:   wb_start_src = SRC_MEM;
            E_IO_REL: wb_start_src = SRC_IO;
            default:  wb_start_src = SRC_ALU;
        endcase
    end

endmodule

// File: rtl/fetch_sequencer.sv
module fetch_sequencer
(
    input  logic                clk,
    input  logic                reset,
    input  ctrl_pkg::opcode_t   opcode,
    input  logic                instr_valid,
    input  logic                irq_pending,
    input  logic                exec_idle,
    output logic                fetch_req,
    output logic                ir_load,
    output logic                imm_load,
    output logic                irq_ack,
    output logic                issue,
    output ctrl_pkg::op_class_t issue_class,
    output ctrl_pkg::alu_op_t   issue_alu_op,
    output logic                issue_imm
);
    import ctrl_pkg::*;

    typedef enum logic [2:0]
    {
        F_HEAD,
        F_IRQ_SAVE,
        F_FETCH,
        F_IMM_WAIT,
        F_ISSUE_WAIT
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t state_next;

    op_class_t dec_class;
    alu_op_t   dec_alu_op;
    logic      dec_imm;

    opcode_decoder u_decoder
    (
        .opcode    (opcode),
        .op_class  (dec_class),
        .alu_op    (dec_alu_op),
        .needs_imm (dec_imm)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= F_HEAD;
        else
            state <= state_next;
    end

    // decode register, held until issue
    always_ff @(posedge clk)
    begin
        if (ir_load)
        begin
            issue_class  <= dec_class;
            issue_alu_op <= dec_alu_op;
            issue_imm    <= dec_imm;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            F_HEAD,
            F_IRQ_SAVE:
                state_next = F_FETCH;
            F_FETCH:
            begin
                if (instr_valid)
                    state_next = dec_imm ? F_IMM_WAIT : F_ISSUE_WAIT;
            end
            F_IMM_WAIT:
            begin
                if (instr_valid)
                    state_next = F_ISSUE_WAIT;
            end
            F_ISSUE_WAIT:
            begin
                // interrupt is taken only at an issue boundary
                if (exec_idle)
                    state_next = irq_pending ? F_IRQ_SAVE : F_FETCH;
            end
            default:
                state_next = F_HEAD;
        endcase
    end

    assign fetch_req = (state == F_FETCH) || (state == F_IMM_WAIT);
    assign ir_load   = (state == F_FETCH) && instr_valid;
    assign imm_load  = (state == F_IMM_WAIT) && instr_valid;
    assign irq_ack   = (state == F_IRQ_SAVE);
    assign issue     = (state == F_ISSUE_WAIT) && exec_idle;

endmodule

// File: rtl/opcode_decoder.sv
module opcode_decoder
(
    input  ctrl_pkg::opcode_t   opcode,
    output ctrl_pkg::op_class_t op_class,
    output ctrl_pkg::alu_op_t   alu_op,
    output logic                needs_imm
);
    import ctrl_pkg::*;

    always_comb
    begin
        // anything not matched below is illegal
        op_class  = CLASS_ILLEGAL;
        alu_op    = '0;
        needs_imm = 1'b0;

        if (opcode <= OPC_ALU_LAST)
        begin
            op_class  = CLASS_ALU;
            alu_op    = opcode[ALU_OP_MSB:ALU_OP_LSB];
            needs_imm = opcode[IMM_BIT];
        end
        else
        begin
            case (opcode)
                OPC_LOAD:
                    op_class = CLASS_LOAD;
                OPC_LOAD_IMM:
                begin
                    op_class  = CLASS_LOAD;
                    needs_imm = 1'b1;
                end
                OPC_STORE:
                    op_class = CLASS_STORE;
                OPC_STORE_IMM:
                begin
                    op_class  = CLASS_STORE;
                    needs_imm = 1'b1;
                end
                OPC_IO_IN:
                    op_class = CLASS_IO_IN;
                OPC_IO_OUT:
                    op_class = CLASS_IO_OUT;
                default:
                    op_class = CLASS_ILLEGAL;
            endcase
        end
    end

endmodule

// File: rtl/pipeline_controller.sv
module pipeline_controller
(
    input  logic              clk,
    input  logic              reset,
    input  ctrl_pkg::opcode_t opcode,
    input  logic              instr_valid,
    input  logic              irq_pending,
    input  logic              data_valid,
    input  logic              io_ack,
    output logic              fetch_req,
    output logic              ir_load,
    output logic              imm_load,
    output logic              irq_ack,
    output logic              alu_en,
    output ctrl_pkg::alu_op_t alu_op,
    output logic              alu_use_imm,
    output logic              mem_read,
    output logic              mem_write,
    output logic              io_req,
    output logic              io_dir,
    output logic              illegal_op,
    output logic              reg_write,
    output ctrl_pkg::wb_src_t wb_src
);
    import ctrl_pkg::*;

    ////////////////////////////////////////////////////////////
    // stage to stage hand-off
    ////////////////////////////////////////////////////////////

    logic      issue;
    op_class_t issue_class;
    alu_op_t   issue_alu_op;
    logic      issue_imm;
    logic      exec_idle;
    logic      wb_start;
    wb_src_t   wb_start_src;
    logic      wb_idle;

    fetch_sequencer u_fetch
    (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .instr_valid  (instr_valid),
        .irq_pending  (irq_pending),
        .exec_idle    (exec_idle),
        .fetch_req    (fetch_req),
        .ir_load      (ir_load),
        .imm_load     (imm_load),
        .irq_ack      (irq_ack),
        .issue        (issue),
        .issue_class  (issue_class),
        .issue_alu_op (issue_alu_op),
        .issue_imm    (issue_imm)
    );

    execute_sequencer u_execute
    (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .issue_class  (issue_class),
        .issue_alu_op (issue_alu_op),
        .issue_imm    (issue_imm),
        .wb_idle      (wb_idle),
        .data_valid   (data_valid),
        .io_ack       (io_ack),
        .exec_idle    (exec_idle),
        .alu_en       (alu_en),
        .alu_op       (alu_op),
        .alu_use_imm  (alu_use_imm),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .io_req       (io_req),
        .io_dir       (io_dir),
        .illegal_op   (illegal_op),
        .wb_start     (wb_start),
        .wb_start_src (wb_start_src)
    );

    writeback_sequencer u_writeback
    (
        .clk          (clk),
        .reset        (reset),
        .wb_start     (wb_start),
        .wb_start_src (wb_start_src),
        .data_valid   (data_valid),
        .wb_idle      (wb_idle),
        .reg_write    (reg_write),
        .wb_src       (wb_src)
    );

endmodule

// File: rtl/writeback_sequencer.sv
module writeback_sequencer
(
    input  logic              clk,
    input  logic              reset,
    input  logic              wb_start,
    input  ctrl_pkg::wb_src_t wb_start_src,
    input  logic              data_valid,
    output logic              wb_idle,
    output logic              reg_write,
    output ctrl_pkg::wb_src_t wb_src
);
    import ctrl_pkg::*;

    typedef enum logic [1:0]
    {
        W_IDLE,
        W_WRITE,
        W_MEM_WAIT
    } wb_state_t;

    wb_state_t state;
    wb_src_t   src_q;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= W_IDLE;
        else
        begin
            case (state)
                W_IDLE:
                begin
                    if (wb_start)
                        state <= (wb_start_src == SRC_MEM) ? W_MEM_WAIT : W_WRITE;
                end
                W_WRITE:
                    state <= W_IDLE;
                W_MEM_WAIT:
                begin
                    // load data shows up on the shared data_valid
                    if (data_valid)
                        state <= W_IDLE;
                end
                default:
                    state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wb_start)
            src_q <= wb_start_src;
    end

    assign wb_idle   = (state == W_IDLE);
    assign reg_write = (state == W_WRITE) || ((state == W_MEM_WAIT) && data_valid);
    assign wb_src    = reg_write ? src_q : SRC_ALU;

endmodule

// File: test/tb_pipeline_controller.sv
module tb_pipeline_controller;
    timeunit 1ns;
    timeprecision 1ps;

    import ctrl_pkg::*;

    localparam int ALU_COUNT = 8;
    localparam int TIMEOUT_CYCLES = 12 + ALU_COUNT * 14 + 4 * 20 + 4 * 24 + 2 * 14 + 100;

    logic       clk;
    logic       reset;
    opcode_t    opcode;
    logic       instr_valid;
    logic       irq_pending;
    logic       data_valid;
    logic       io_ack;
    logic       fetch_req;
    logic       ir_load;
    logic       imm_load;
    logic       irq_ack;
    logic       alu_en;
    alu_op_t    alu_op;
    logic       alu_use_imm;
    logic       mem_read;
    logic       mem_write;
    logic       io_req;
    logic       io_dir;
    logic       illegal_op;
    logic       reg_write;
    wb_src_t    wb_src;

    integer     seed;
    int         cycle_count;

    pipeline_controller u_dut
    (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .instr_valid (instr_valid),
        .irq_pending (irq_pending),
        .data_valid  (data_valid),
        .io_ack      (io_ack),
        .fetch_req   (fetch_req),
        .ir_load     (ir_load),
        .imm_load    (imm_load),
        .irq_ack     (irq_ack),
        .alu_en      (alu_en),
        .alu_op      (alu_op),
        .alu_use_imm (alu_use_imm),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .io_req      (io_req),
        .io_dir      (io_dir),
        .illegal_op  (illegal_op),
        .reg_write   (reg_write),
        .wb_src      (wb_src)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        cycle_count = 0;
        forever
        begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > TIMEOUT_CYCLES)
                report_failure("timeout, the tests did not finish in time");
        end
    end

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("mismatch at %0d ns: %s is %b, expected %b",
                                     $time, name, got, exp));
    endtask

    task automatic check_alu_op(input string name, input alu_op_t got, input alu_op_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic check_src(input string name, input wb_src_t got, input wb_src_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch at %0d ns: %s is %0d, expected %0d",
                                     $time, name, got, exp));
    endtask

    // every output idle apart from fetch_req
    task automatic check_quiet(input logic fetch_exp);
        check_bit("fetch_req", fetch_req, fetch_exp);
        check_bit("ir_load", ir_load, 1'b0);
        check_bit("imm_load", imm_load, 1'b0);
        check_bit("irq_ack", irq_ack, 1'b0);
        check_bit("alu_en", alu_en, 1'b0);
        check_alu_op("alu_op", alu_op, '0);
        check_bit("alu_use_imm", alu_use_imm, 1'b0);
        check_bit("mem_read", mem_read, 1'b0);
        check_bit("mem_write", mem_write, 1'b0);
        check_bit("io_req", io_req, 1'b0);
        check_bit("io_dir", io_dir, 1'b0);
        check_bit("illegal_op", illegal_op, 1'b0);
        check_bit("reg_write", reg_write, 1'b0);
        check_src("wb_src", wb_src, SRC_ALU);
    endtask

    function automatic logic strobe_level(input string name);
        if (name == "fetch_req")
            return fetch_req;
        else if (name == "mem_read")
            return mem_read;
        else if (name == "mem_write")
            return mem_write;
        else if (name == "io_req")
            return io_req;
        return 1'b0;
    endfunction

    // returns at the first later falling edge where the strobe is high
    task automatic wait_for_strobe(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!strobe_level(name))
        begin
            waited++;
            if (waited >= 20)
                report_failure({name, " never arrived within 20 cycles"});
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic int random_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // immediate forms per the opcode map
    function automatic logic takes_imm(input opcode_t op);
        if (op <= 6'o37)
            return op[0];
        return (op == OPC_LOAD_IMM) || (op == OPC_STORE_IMM);
    endfunction

    task automatic present_word(input opcode_t word, input logic is_imm);
        wait_for_strobe("fetch_req");
        @(posedge clk);
        opcode      <= word;
        instr_valid <= 1'b1;
        @(negedge clk);
        check_bit("ir_load", ir_load, !is_imm);
        check_bit("imm_load", imm_load, is_imm);
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic fetch_instr(input opcode_t op);
        present_word(op, 1'b0);
        if (takes_imm(op))
            present_word(opcode_t'(random_below(64)), 1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_sequence();
        repeat (7)
        begin
            @(negedge clk);
            check_quiet(1'b0);
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_quiet(1'b0);
        @(negedge clk);
        check_quiet(1'b1);
    endtask

    // alu_en two cycles and reg_write three cycles after the last word
    task automatic alu_ops();
        opcode_t op;
        for (int i = 0; i < ALU_COUNT; i++)
        begin
            op = opcode_t'(random_below(16) * 2 + (i % 2));
            fetch_instr(op);
            @(negedge clk);
            check_bit("alu_en", alu_en, 1'b0);
            @(negedge clk);
            check_bit("alu_en", alu_en, 1'b1);
            check_alu_op("alu_op", alu_op, op[4:1]);
            check_bit("alu_use_imm", alu_use_imm, op[0]);
            check_bit("reg_write", reg_write, 1'b0);
            @(negedge clk);
            check_bit("alu_en", alu_en, 1'b0);
            check_bit("reg_write", reg_write, 1'b1);
            check_src("wb_src", wb_src, SRC_ALU);
        end
    endtask

    task automatic load_store(input opcode_t op);
        logic is_load;
        int   delay;
        is_load = (op == OPC_LOAD) || (op == OPC_LOAD_IMM);
        fetch_instr(op);
        delay = random_below(4);
        wait_for_strobe(is_load ? "mem_read" : "mem_write");
        repeat (delay)
        begin
            @(negedge clk);
            check_bit("mem_read", mem_read, 1'b0);
            check_bit("mem_write", mem_write, !is_load);
            check_bit("reg_write", reg_write, 1'b0);
        end
        @(posedge clk);
        data_valid <= 1'b1;
        @(negedge clk);
        check_bit("mem_read", mem_read, 1'b0);
        check_bit("mem_write", mem_write, !is_load);
        check_bit("reg_write", reg_write, is_load);
        if (is_load)
            check_src("wb_src", wb_src, SRC_MEM);
        @(posedge clk);
        data_valid <= 1'b0;
        @(negedge clk);
        check_bit("mem_write", mem_write, 1'b0);
        check_bit("reg_write", reg_write, 1'b0);
    endtask

    task automatic io_transfer(input opcode_t op);
        logic is_out;
        int   delay;
        is_out = (op == OPC_IO_OUT);
        fetch_instr(op);
        wait_for_strobe("io_req");
        check_bit("io_dir", io_dir, is_out);
        delay = random_below(4);
        repeat (delay)
        begin
            @(negedge clk);
            check_bit("io_req", io_req, 1'b1);
            check_bit("io_dir", io_dir, is_out);
        end
        @(posedge clk);
        io_ack <= 1'b1;
        @(negedge clk);
        check_bit("io_req", io_req, 1'b1);
        // request must drop while the acknowledge is still high
        delay = random_below(4);
        repeat (delay + 1)
        begin
            @(negedge clk);
            check_bit("io_req", io_req, 1'b0);
            check_bit("reg_write", reg_write, 1'b0);
        end
        @(posedge clk);
        io_ack <= 1'b0;
        @(negedge clk);
        check_bit("reg_write", reg_write, 1'b0);
        @(negedge clk);
        check_bit("reg_write", reg_write, !is_out);
        if (!is_out)
            check_src("wb_src", wb_src, SRC_IO);
        @(negedge clk);
        check_bit("reg_write", reg_write, 1'b0);
    endtask

    task automatic interrupt_entry();
        @(posedge clk);
        irq_pending <= 1'b1;
        fetch_instr(opcode_t'(random_below(16) * 2));
        @(negedge clk);
        check_bit("irq_ack", irq_ack, 1'b0);
        @(posedge clk);
        irq_pending <= 1'b0;
        @(negedge clk);
        check_bit("irq_ack", irq_ack, 1'b1);
        check_bit("fetch_req", fetch_req, 1'b0);
        @(negedge clk);
        check_bit("irq_ack", irq_ack, 1'b0);
        check_bit("fetch_req", fetch_req, 1'b1);
    endtask

    // undefined opcodes 46 through 77 octal
    task automatic illegal_opcode();
        opcode_t op;
        op = opcode_t'(6'o46 + random_below(26));
        fetch_instr(op);
        for (int i = 1; i <= 4; i++)
        begin
            @(negedge clk);
            check_bit("illegal_op", illegal_op, i == 2);
            check_bit("alu_en", alu_en, 1'b0);
            check_bit("mem_read", mem_read, 1'b0);
            check_bit("mem_write", mem_write, 1'b0);
            check_bit("io_req", io_req, 1'b0);
            check_bit("reg_write", reg_write, 1'b0);
        end
    endtask

    initial
    begin
        seed        = 32'h75fd;
        reset       = 1'b1;
        opcode      = '0;
        instr_valid = 1'b0;
        irq_pending = 1'b0;
        data_valid  = 1'b0;
        io_ack      = 1'b0;

        reset_sequence();
        alu_ops();
        load_store(OPC_LOAD);
        load_store(OPC_STORE);
        load_store(OPC_LOAD_IMM);
        load_store(OPC_STORE_IMM);
        io_transfer(OPC_IO_IN);
        io_transfer(OPC_IO_OUT);
        io_transfer(OPC_IO_OUT);
        io_transfer(OPC_IO_IN);
        interrupt_entry();
        illegal_opcode();

        repeat (4) @(negedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule
